//--- frame_buffer_pkg.sv
package frame_buffer_pkg;

	// image geometry
	localparam int IMAGE_WIDTH  = 64;
	localparam int IMAGE_HEIGHT = 48;
	localparam int X_W          = 6;
	localparam int Y_W          = 6;

	// two horizontally adjacent pixels share one memory word
	localparam int WORDS_PER_LINE  = IMAGE_WIDTH / 2;
	localparam int WORDS_PER_FRAME = WORDS_PER_LINE * IMAGE_HEIGHT;

	// bank layout
	localparam int SLOTS_PER_BANK = 3;
	localparam int SLOT_W         = 2;
	localparam int ADDR_W         = 13;
	localparam int MEM_W          = 36;

	// one-hot client codes
	localparam int CLIENT_W = 3;
	localparam logic [CLIENT_W-1:0] CLIENT_NONE    = 3'b000;
	localparam logic [CLIENT_W-1:0] CLIENT_CAPTURE = 3'b100;
	localparam logic [CLIENT_W-1:0] CLIENT_DISPLAY = 3'b010;
	localparam logic [CLIENT_W-1:0] CLIENT_FILTER  = 3'b001;

	// frame role placement after reset
	localparam logic              RESET_CAPTURE_BANK = 1'b0;
	localparam logic [SLOT_W-1:0] RESET_CAPTURE_SLOT = 2'd0;
	localparam logic              RESET_PROCESS_BANK = 1'b0;
	localparam logic [SLOT_W-1:0] RESET_PROCESS_SLOT = 2'd1;
	localparam logic              RESET_NEXT_BANK    = 1'b1;
	localparam logic [SLOT_W-1:0] RESET_NEXT_SLOT    = 2'd0;
	localparam logic              RESET_DISPLAY_BANK = 1'b1;
	localparam logic [SLOT_W-1:0] RESET_DISPLAY_SLOT = 2'd1;

endpackage

//--- frame_role_rotator.sv
`timescale 1ns/1ns

module frame_role_rotator (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              frame_flag,
	output logic                              capture_bank,
	output logic                              process_bank,
	output logic                              display_bank,
	output logic [frame_buffer_pkg::SLOT_W-1:0] capture_slot,
	output logic [frame_buffer_pkg::SLOT_W-1:0] process_slot,
	output logic [frame_buffer_pkg::SLOT_W-1:0] display_slot
);
	import frame_buffer_pkg::*;

	// next-display role, not bound to any client
	logic              next_bank;
	logic [SLOT_W-1:0] next_slot;

	always_ff @(posedge clk) begin
		if (reset) begin
			capture_bank <= RESET_CAPTURE_BANK;
			capture_slot <= RESET_CAPTURE_SLOT;
			process_bank <= RESET_PROCESS_BANK;
			process_slot <= RESET_PROCESS_SLOT;
			next_bank    <= RESET_NEXT_BANK;
			next_slot    <= RESET_NEXT_SLOT;
			display_bank <= RESET_DISPLAY_BANK;
			display_slot <= RESET_DISPLAY_SLOT;
		end else if (frame_flag) begin
			// captured frame moves toward display via next-display
			capture_bank <= process_bank;
			capture_slot <= process_slot;
			process_bank <= display_bank;
			process_slot <= display_slot;
			next_bank    <= capture_bank;
			next_slot    <= capture_slot;
			display_bank <= next_bank;
			display_slot <= next_slot;
		end
	end

endmodule

//--- pixel_address.sv
`timescale 1ns/1ns

module pixel_address (
	input  logic [frame_buffer_pkg::X_W-1:0]    x,
	input  logic [frame_buffer_pkg::Y_W-1:0]    y,
	input  logic [frame_buffer_pkg::SLOT_W-1:0] slot,
	output logic [frame_buffer_pkg::ADDR_W-1:0] addr
);
	import frame_buffer_pkg::*;

	logic [ADDR_W-1:0] slot_offset;
	logic [ADDR_W-1:0] line_offset;
	logic [ADDR_W-1:0] word_offset;

	// base of the frame slot inside the bank
	assign slot_offset = ADDR_W'(slot) * ADDR_W'(WORDS_PER_FRAME);

	// start of the line within the frame
	assign line_offset = ADDR_W'(y) * ADDR_W'(WORDS_PER_LINE);

	// even and odd x land in the same word
	assign word_offset = ADDR_W'(x >> 1);

	assign addr = slot_offset + line_offset + word_offset;

endmodule

//--- bank_arbiter.sv
`timescale 1ns/1ns

module bank_arbiter (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  capture_req,
	input  logic                                  display_req,
	input  logic                                  filter_req,
	input  logic [frame_buffer_pkg::ADDR_W-1:0]   capture_addr,
	input  logic [frame_buffer_pkg::ADDR_W-1:0]   display_addr,
	input  logic [frame_buffer_pkg::ADDR_W-1:0]   filter_addr,
	input  logic [frame_buffer_pkg::MEM_W-1:0]    capture_pixel,
	input  logic [frame_buffer_pkg::MEM_W-1:0]    filter_pixel_write,
	input  logic                                  filter_wr,
	output logic [frame_buffer_pkg::ADDR_W-1:0]   mem_addr,
	output logic [frame_buffer_pkg::MEM_W-1:0]    mem_write,
	output logic                                  mem_wr,
	output logic [frame_buffer_pkg::CLIENT_W-1:0] granted,
	output logic [frame_buffer_pkg::CLIENT_W-1:0] read_tag
);
	import frame_buffer_pkg::*;

	logic [ADDR_W-1:0]   next_addr;
	logic [MEM_W-1:0]    next_write;
	logic                next_wr;
	logic [CLIENT_W-1:0] next_granted;
	logic [CLIENT_W-1:0] next_tag;

	// capture beats display, display beats filter
	always_comb begin
		next_addr    = mem_addr;
		next_write   = mem_write;
		next_wr      = 1'b0;
		next_granted = CLIENT_NONE;
		next_tag     = CLIENT_NONE;
		if (capture_req) begin
			next_addr    = capture_addr;
			next_write   = capture_pixel;
			next_wr      = 1'b1;
			next_granted = CLIENT_CAPTURE;
		end else if (display_req) begin
			next_addr    = display_addr;
			next_granted = CLIENT_DISPLAY;
			next_tag     = CLIENT_DISPLAY;
		end else if (filter_req) begin
			next_addr    = filter_addr;
			next_write   = filter_pixel_write;
			next_wr      = filter_wr;
			next_granted = CLIENT_FILTER;
			// only a filter read expects data back
			next_tag     = filter_wr ? CLIENT_NONE : CLIENT_FILTER;
		end
	end

	always_ff @(posedge clk) begin
		mem_addr  <= next_addr;
		mem_write <= next_write;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wr   <= 1'b0;
			granted  <= CLIENT_NONE;
			read_tag <= CLIENT_NONE;
		end else begin
			mem_wr   <= next_wr;
			granted  <= next_granted;
			read_tag <= next_tag;
		end
	end

endmodule

//--- frame_bank.sv
`timescale 1ns/1ns

module frame_bank (
	input  logic                                clk,
	input  logic [frame_buffer_pkg::ADDR_W-1:0] mem_addr,
	input  logic [frame_buffer_pkg::MEM_W-1:0]  mem_write,
	input  logic                                mem_wr,
	output logic [frame_buffer_pkg::MEM_W-1:0]  mem_read
);
	import frame_buffer_pkg::*;

	// three frame slots back to back
	logic [MEM_W-1:0] ram [0:SLOTS_PER_BANK*WORDS_PER_FRAME-1];

	always_ff @(posedge clk) begin
		if (mem_wr) begin
			ram[mem_addr] <= mem_write;
		end
	end

	// registered read, old contents on a write cycle
	always_ff @(posedge clk) begin
		mem_read <= ram[mem_addr];
	end

endmodule

//--- read_return.sv
`timescale 1ns/1ns

module read_return (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [frame_buffer_pkg::CLIENT_W-1:0] read_tag0,
	input  logic [frame_buffer_pkg::CLIENT_W-1:0] read_tag1,
	input  logic [frame_buffer_pkg::MEM_W-1:0]    mem_read0,
	input  logic [frame_buffer_pkg::MEM_W-1:0]    mem_read1,
	output logic [frame_buffer_pkg::MEM_W-1:0]    display_pixel,
	output logic [frame_buffer_pkg::MEM_W-1:0]    filter_pixel_read
);
	import frame_buffer_pkg::*;

	// tags delayed to match the ram read latency
	logic [CLIENT_W-1:0] tag0_q;
	logic [CLIENT_W-1:0] tag1_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			tag0_q <= CLIENT_NONE;
			tag1_q <= CLIENT_NONE;
		end else begin
			tag0_q <= read_tag0;
			tag1_q <= read_tag1;
		end
	end

	// held pixels, bank 0 first when both banks tag one client
	always_ff @(posedge clk) begin
		if (reset) begin
			display_pixel     <= '0;
			filter_pixel_read <= '0;
		end else begin
			if (tag0_q == CLIENT_DISPLAY) begin
				display_pixel <= mem_read0;
			end else if (tag1_q == CLIENT_DISPLAY) begin
				display_pixel <= mem_read1;
			end
			if (tag0_q == CLIENT_FILTER) begin
				filter_pixel_read <= mem_read0;
			end else if (tag1_q == CLIENT_FILTER) begin
				filter_pixel_read <= mem_read1;
			end
		end
	end

endmodule

//--- frame_buffer_top.sv
`timescale 1ns/1ns

module frame_buffer_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                frame_flag,
	input  logic                                capture_flag,
	input  logic [frame_buffer_pkg::X_W-1:0]    capture_x,
	input  logic [frame_buffer_pkg::Y_W-1:0]    capture_y,
	input  logic [frame_buffer_pkg::MEM_W-1:0]  capture_pixel,
	output logic                                capture_done,
	input  logic                                filter_flag,
	input  logic                                filter_wr,
	input  logic [frame_buffer_pkg::X_W-1:0]    filter_x,
	input  logic [frame_buffer_pkg::Y_W-1:0]    filter_y,
	input  logic [frame_buffer_pkg::MEM_W-1:0]  filter_pixel_write,
	output logic [frame_buffer_pkg::MEM_W-1:0]  filter_pixel_read,
	output logic                                filter_done,
	input  logic                                display_flag,
	input  logic [frame_buffer_pkg::X_W-1:0]    display_x,
	input  logic [frame_buffer_pkg::Y_W-1:0]    display_y,
	output logic [frame_buffer_pkg::MEM_W-1:0]  display_pixel,
	output logic                                display_done
);
	import frame_buffer_pkg::*;

	logic                capture_bank;
	logic                process_bank;
	logic                display_bank;
	logic [SLOT_W-1:0]   capture_slot;
	logic [SLOT_W-1:0]   process_slot;
	logic [SLOT_W-1:0]   display_slot;
	logic [ADDR_W-1:0]   capture_addr;
	logic [ADDR_W-1:0]   filter_addr;
	logic [ADDR_W-1:0]   display_addr;
	logic [ADDR_W-1:0]   mem_addr0;
	logic [ADDR_W-1:0]   mem_addr1;
	logic [MEM_W-1:0]    mem_write0;
	logic [MEM_W-1:0]    mem_write1;
	logic [MEM_W-1:0]    mem_read0;
	logic [MEM_W-1:0]    mem_read1;
	logic                mem_wr0;
	logic                mem_wr1;
	logic [CLIENT_W-1:0] granted0;
	logic [CLIENT_W-1:0] granted1;
	logic [CLIENT_W-1:0] read_tag0;
	logic [CLIENT_W-1:0] read_tag1;

	frame_role_rotator frame_role_rotator_inst (
		.clk          (clk),
		.reset        (reset),
		.frame_flag   (frame_flag),
		.capture_bank (capture_bank),
		.process_bank (process_bank),
		.display_bank (display_bank),
		.capture_slot (capture_slot),
		.process_slot (process_slot),
		.display_slot (display_slot)
	);

	// capture on the capture role, filter on process, display on display
	pixel_address capture_address_inst (
		.x    (capture_x),
		.y    (capture_y),
		.slot (capture_slot),
		.addr (capture_addr)
	);

	pixel_address filter_address_inst (
		.x    (filter_x),
		.y    (filter_y),
		.slot (process_slot),
		.addr (filter_addr)
	);

	pixel_address display_address_inst (
		.x    (display_x),
		.y    (display_y),
		.slot (display_slot),
		.addr (display_addr)
	);

	// each request only reaches the bank holding its role
	bank_arbiter bank_arbiter0_inst (
		.clk                (clk),
		.reset              (reset),
		.capture_req        (capture_flag && !capture_bank),
		.display_req        (display_flag && !display_bank),
		.filter_req         (filter_flag && !process_bank),
		.capture_addr       (capture_addr),
		.display_addr       (display_addr),
		.filter_addr        (filter_addr),
		.capture_pixel      (capture_pixel),
		.filter_pixel_write (filter_pixel_write),
		.filter_wr          (filter_wr),
		.mem_addr           (mem_addr0),
		.mem_write          (mem_write0),
		.mem_wr             (mem_wr0),
		.granted            (granted0),
		.read_tag           (read_tag0)
	);

	bank_arbiter bank_arbiter1_inst (
		.clk                (clk),
		.reset              (reset),
		.capture_req        (capture_flag && capture_bank),
		.display_req        (display_flag && display_bank),
		.filter_req         (filter_flag && process_bank),
		.capture_addr       (capture_addr),
		.display_addr       (display_addr),
		.filter_addr        (filter_addr),
		.capture_pixel      (capture_pixel),
		.filter_pixel_write (filter_pixel_write),
		.filter_wr          (filter_wr),
		.mem_addr           (mem_addr1),
		.mem_write          (mem_write1),
		.mem_wr             (mem_wr1),
		.granted            (granted1),
		.read_tag           (read_tag1)
	);

	frame_bank frame_bank0_inst (
		.clk       (clk),
		.mem_addr  (mem_addr0),
		.mem_write (mem_write0),
		.mem_wr    (mem_wr0),
		.mem_read  (mem_read0)
	);

	frame_bank frame_bank1_inst (
		.clk       (clk),
		.mem_addr  (mem_addr1),
		.mem_write (mem_write1),
		.mem_wr    (mem_wr1),
		.mem_read  (mem_read1)
	);

	read_return read_return_inst (
		.clk               (clk),
		.reset             (reset),
		.read_tag0         (read_tag0),
		.read_tag1         (read_tag1),
		.mem_read0         (mem_read0),
		.mem_read1         (mem_read1),
		.display_pixel     (display_pixel),
		.filter_pixel_read (filter_pixel_read)
	);

	// a client is done when either bank served it
	assign capture_done = (granted0 == CLIENT_CAPTURE) || (granted1 == CLIENT_CAPTURE);
	assign display_done = (granted0 == CLIENT_DISPLAY) || (granted1 == CLIENT_DISPLAY);
	assign filter_done  = (granted0 == CLIENT_FILTER) || (granted1 == CLIENT_FILTER);

endmodule

//--- frame_buffer_tb.sv
`timescale 1ns/1ns

module frame_buffer_tb;
	import frame_buffer_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;
	localparam int CAPTURE_ID     = 0;
	localparam int FILTER_ID      = 1;
	localparam int DISPLAY_ID     = 2;

	logic             clk;
	logic             reset;
	logic             frame_flag;
	logic             capture_flag;
	logic [X_W-1:0]   capture_x;
	logic [Y_W-1:0]   capture_y;
	logic [MEM_W-1:0] capture_pixel;
	logic             capture_done;
	logic             filter_flag;
	logic             filter_wr;
	logic [X_W-1:0]   filter_x;
	logic [Y_W-1:0]   filter_y;
	logic [MEM_W-1:0] filter_pixel_write;
	logic [MEM_W-1:0] filter_pixel_read;
	logic             filter_done;
	logic             display_flag;
	logic [X_W-1:0]   display_x;
	logic [Y_W-1:0]   display_y;
	logic [MEM_W-1:0] display_pixel;
	logic             display_done;

	int value_errors;
	int timeout_errors;
	int other_errors;

	frame_buffer_top frame_buffer_top_inst (
		.clk                (clk),
		.reset              (reset),
		.frame_flag         (frame_flag),
		.capture_flag       (capture_flag),
		.capture_x          (capture_x),
		.capture_y          (capture_y),
		.capture_pixel      (capture_pixel),
		.capture_done       (capture_done),
		.filter_flag        (filter_flag),
		.filter_wr          (filter_wr),
		.filter_x           (filter_x),
		.filter_y           (filter_y),
		.filter_pixel_write (filter_pixel_write),
		.filter_pixel_read  (filter_pixel_read),
		.filter_done        (filter_done),
		.display_flag       (display_flag),
		.display_x          (display_x),
		.display_y          (display_y),
		.display_pixel      (display_pixel),
		.display_done       (display_done)
	);

	always #5 clk = ~clk;

	function automatic logic client_done(input int client);
		case (client)
			CAPTURE_ID: return capture_done;
			FILTER_ID:  return filter_done;
			default:    return display_done;
		endcase
	endfunction

	function automatic string client_name(input int client);
		case (client)
			CAPTURE_ID: return "capture";
			FILTER_ID:  return "filter";
			default:    return "display";
		endcase
	endfunction

	function automatic int error_total();
		return value_errors + timeout_errors + other_errors;
	endfunction

	// returns at the falling edge where done was seen
	task automatic wait_done(input int client);
		int  cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (client_done(client)) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			$display("timeout: %s request was never done", client_name(client));
			timeout_errors++;
		end
	endtask

	task automatic compare_word(input string what, input logic [MEM_W-1:0] got,
			input logic [MEM_W-1:0] expected);
		if (got !== expected) begin
			$display("FAILED at %0t ns: %s read %h, expected %h", $time, what, got, expected);
			value_errors++;
		end
	endtask

	// held pixel is loaded two edges after the done cycle
	task automatic settle_read();
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic capture_write(input int x, input int y, input logic [MEM_W-1:0] data);
		capture_x = X_W'(x);
		capture_y = Y_W'(y);
		capture_pixel = data;
		capture_flag = 1'b1;
		wait_done(CAPTURE_ID);
		capture_flag = 1'b0;
	endtask

	task automatic filter_request(input int x, input int y, input logic wr,
			input logic [MEM_W-1:0] data);
		filter_x = X_W'(x);
		filter_y = Y_W'(y);
		filter_wr = wr;
		filter_pixel_write = data;
		filter_flag = 1'b1;
		wait_done(FILTER_ID);
		filter_flag = 1'b0;
	endtask

	task automatic filter_read(input int x, input int y, input logic [MEM_W-1:0] expected);
		filter_request(x, y, 1'b0, '0);
		settle_read();
		compare_word("filter", filter_pixel_read, expected);
	endtask

	task automatic display_read(input int x, input int y, input logic [MEM_W-1:0] expected);
		display_x = X_W'(x);
		display_y = Y_W'(y);
		display_flag = 1'b1;
		wait_done(DISPLAY_ID);
		display_flag = 1'b0;
		settle_read();
		compare_word("display", display_pixel, expected);
	endtask

	task automatic frame_pulse();
		frame_flag = 1'b1;
		@(negedge clk);
		frame_flag = 1'b0;
	endtask

	// capture and a second client raised together
	task automatic dual_request(input int second, input int x, input int y,
			input logic [MEM_W-1:0] data, input logic [MEM_W-1:0] aux);
		int cycles;
		int capture_cycle;
		int second_cycle;
		capture_x = X_W'(x);
		capture_y = Y_W'(y);
		capture_pixel = data;
		capture_flag = 1'b1;
		if (second == FILTER_ID) begin
			filter_x = X_W'(x);
			filter_y = Y_W'(y);
			filter_wr = 1'b1;
			filter_pixel_write = aux;
			filter_flag = 1'b1;
		end else begin
			display_x = X_W'(x);
			display_y = Y_W'(y);
			display_flag = 1'b1;
		end
		cycles = 0;
		capture_cycle = 0;
		second_cycle = 0;
		while ((capture_cycle == 0 || second_cycle == 0) && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (capture_done && capture_cycle == 0) begin
				capture_cycle = cycles;
				capture_flag = 1'b0;
			end
			if (client_done(second) && second_cycle == 0) begin
				second_cycle = cycles;
				filter_flag = 1'b0;
				display_flag = 1'b0;
			end
		end
		capture_flag = 1'b0;
		filter_flag = 1'b0;
		display_flag = 1'b0;
		if (capture_cycle == 0 || second_cycle == 0) begin
			$display("timeout: capture and %s requests did not both finish", client_name(second));
			timeout_errors++;
		end else if (second == FILTER_ID) begin
			if (capture_cycle >= second_cycle) begin
				$display("FAILED at %0t ns: capture done in cycle %0d, filter in cycle %0d",
					$time, capture_cycle, second_cycle);
				value_errors++;
			end
		end else begin
			if (capture_cycle != second_cycle) begin
				$display("FAILED at %0t ns: capture done in cycle %0d, display in cycle %0d",
					$time, capture_cycle, second_cycle);
				value_errors++;
			end
			settle_read();
			compare_word("display", display_pixel, aux);
		end
	endtask

	initial begin
		int    fd;
		int    code;
		int    fields;
		int    op;
		int    x;
		int    y;
		int    operations;
		string line;
		logic [MEM_W-1:0] data;
		logic [MEM_W-1:0] aux;

		value_errors = 0;
		timeout_errors = 0;
		other_errors = 0;
		operations = 0;
		clk = 1'b0;
		reset = 1'b1;
		frame_flag = 1'b0;
		capture_flag = 1'b0;
		capture_x = '0;
		capture_y = '0;
		capture_pixel = '0;
		filter_flag = 1'b0;
		filter_wr = 1'b0;
		filter_x = '0;
		filter_y = '0;
		filter_pixel_write = '0;
		display_flag = 1'b0;
		display_x = '0;
		display_y = '0;

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// idle outputs straight after reset
		if (capture_done || filter_done || display_done) begin
			$display("FAILED at %0t ns: a done output is high after reset", $time);
			value_errors++;
		end
		compare_word("filter after reset", filter_pixel_read, '0);
		compare_word("display after reset", display_pixel, '0);

		fd = $fopen("frame_buffer_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file frame_buffer_stimulus.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code != 0 && line.len() > 0 && line[0] != "#") begin
					fields = $sscanf(line, "%d %d %d %h %h", op, x, y, data, aux);
					if (fields == 5) begin
						operations++;
						case (op)
							0: capture_write(x, y, data);
							1: filter_request(x, y, 1'b1, data);
							2: filter_read(x, y, aux);
							3: display_read(x, y, aux);
							4: frame_pulse();
							5: dual_request(FILTER_ID, x, y, data, aux);
							6: dual_request(DISPLAY_ID, x, y, data, aux);
							default: begin
								$display("unknown operation %0d in the stimulus file", op);
								other_errors++;
							end
						endcase
					end
				end
			end
			$fclose(fd);
			if (operations == 0) begin
				$display("the stimulus file held no operations");
				other_errors++;
			end
		end

		$display("value errors: %0d, timeouts: %0d, other errors: %0d",
			value_errors, timeout_errors, other_errors);
		if (error_total() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- frame_buffer_stimulus.txt
# op x y data aux, x and y decimal, data and aux hex
# op 0 capture write, 1 filter write, 2 filter read, 3 display read, 4 frame pulse, 5 contend, 6 pair
1 4 3 123456789 000000000
2 4 3 000000000 123456789
2 5 3 000000000 123456789
5 8 2 0c0000001 0f0000001
2 8 2 000000000 0f0000001
0 0 0 111111111 000000000
0 2 0 222222222 000000000
0 63 47 333333333 000000000
4 0 0 000000000 000000000
1 20 10 abcdef012 000000000
2 20 10 000000000 abcdef012
4 0 0 000000000 000000000
3 0 0 000000000 111111111
3 3 0 000000000 222222222
3 62 47 000000000 333333333
3 8 2 000000000 0c0000001
4 0 0 000000000 000000000
2 1 0 000000000 111111111
3 4 3 000000000 123456789
3 8 2 000000000 0f0000001
4 0 0 000000000 000000000
6 20 10 555555555 abcdef012
3 21 10 000000000 abcdef012
2 5 3 000000000 123456789

//--- sim.f
frame_buffer_pkg.sv
frame_role_rotator.sv
pixel_address.sv
bank_arbiter.sv
frame_bank.sv
read_return.sv
frame_buffer_top.sv
frame_buffer_tb.sv

//--- Bender.yml
package:
  name: frame_buffer

sources:
  - frame_buffer_pkg.sv
  - frame_role_rotator.sv
  - pixel_address.sv
  - bank_arbiter.sv
  - frame_bank.sv
  - read_return.sv
  - frame_buffer_top.sv
  - target: simulation
    files:
      - frame_buffer_tb.sv
